// File: ringPkg.sv
/* ring node shared definitions: field widths, opcodes, response codes,
   memory sizes, fill patterns, data source codes and the opm union */
package ringPkg;

	localparam int seqW = 16;
	localparam int opmW = 16;
	localparam int addrW = 32;
	localparam int tileW = 128;

	localparam logic [7:0] opIdle = 8'h00;
	localparam logic [7:0] opLdx = 8'h11;
	localparam logic [7:0] opStx = 8'h12;
	localparam logic [7:0] opPfx = 8'h13;
	localparam logic [7:0] opSpx = 8'h14;  // prefetch for store
	localparam logic [3:0] ccmdNibble = 4'h8;  // control command high nibble

	// response kinds, top two bits are always 01
	localparam logic [3:0] kindOkLd = 4'h6;
	localparam logic [3:0] kindOkSt = 4'h7;
	localparam logic [3:0] statusError = 4'b1011;

	localparam int romTiles = 2048;  // 32 KB
	localparam int sramTiles = 512;  // 8 KB
	localparam int romIdxW = $clog2(romTiles);
	localparam int sramIdxW = $clog2(sramTiles);

	localparam logic [tileW-1:0] nopFill = {8{16'h3000}};
	localparam logic [tileW-1:0] rtsFill = {8{16'h3010}};

	localparam int srcW = 3;
	localparam logic [srcW-1:0] srcZero = 3'd0;
	localparam logic [srcW-1:0] srcRom = 3'd1;
	localparam logic [srcW-1:0] srcSram = 3'd2;
	localparam logic [srcW-1:0] srcNop = 3'd3;
	localparam logic [srcW-1:0] srcRts = 3'd4;

	// one opm word, read as a request or written as a response
	typedef union packed {
		struct packed {
			logic [3:0] flags;
			logic [3:0] tag;
			logic [7:0] op;
		} req;
		struct packed {
			logic [3:0] flags;
			logic [3:0] tag;
			logic [3:0] kind;
			logic [3:0] status;  // echoes the request tag
		} resp;
	} ringOpm;

endpackage

// File: ringMsgIf.sv
/* one ring message: sequence, operation mode, address and tile data,
   with producer and consumer views */
`timescale 1ns/1ps

interface ringMsgIf;

	logic [ringPkg::seqW-1:0] seq;
	ringPkg::ringOpm opm;
	logic [ringPkg::addrW-1:0] addr;
	logic [ringPkg::tileW-1:0] data;

	modport src (
		output seq,
		output opm,
		output addr,
		output data
	);

	modport dst (
		input seq,
		input opm,
		input addr,
		input data
	);

endinterface

// File: ringNodeCtrl.sv
/* ring node control: opcode and region decode, SRAM store issue,
   stage register for message and decode */
`timescale 1ns/1ps

module ringNodeCtrl (
	input logic clock,
	input logic rstN,
	ringMsgIf.dst inMsg,
	ringMsgIf.src stageMsg,
	output logic [ringPkg::romIdxW-1:0] romIndex,
	output logic [ringPkg::sramIdxW-1:0] sramIndex,
	output logic sramWrite,
	output logic [ringPkg::tileW-1:0] sramWriteData,
	output logic answer,
	output logic error,
	output logic [ringPkg::srcW-1:0] dataSrc
);

	logic [7:0] op;
	logic isLdx;
	logic isStx;
	logic isPfx;
	logic isMemOp;
	logic isCcmd;
	logic inWin;
	logic isRom;
	logic isSram;
	logic isBad;
	logic [ringPkg::srcW-1:0] srcNext;

	assign op = inMsg.opm.req.op;
	assign isLdx = (op == ringPkg::opLdx);
	assign isStx = (op == ringPkg::opStx);
	assign isPfx = (op == ringPkg::opPfx) || (op == ringPkg::opSpx);
	assign isMemOp = isLdx || isStx || isPfx;
	assign isCcmd = (op[7:4] == ringPkg::ccmdNibble);

	assign inWin = (inMsg.addr[31:18] == '0);  // low 256 KB
	assign isRom = inWin && (inMsg.addr[17:15] == 3'b000);
	assign isSram = inWin && (inMsg.addr[17:13] == 5'b00110);
	assign isBad = (inMsg.addr[31:30] != 2'b00) ||
		((inMsg.addr[31:24] == 8'h00) && !inWin);

	// holes inside the window answer with zero data
	always_comb
	begin
		srcNext = ringPkg::srcZero;
		if (isMemOp && isRom)
			srcNext = ringPkg::srcRom;
		else if (isMemOp && isSram)
			srcNext = ringPkg::srcSram;
		else if (isMemOp && inWin && inMsg.addr[17:16] == 2'b10)
			srcNext = ringPkg::srcNop;
		else if (isMemOp && inWin && inMsg.addr[17:16] == 2'b11)
			srcNext = ringPkg::srcRts;
	end

	assign romIndex = inMsg.addr[4 +: ringPkg::romIdxW];
	assign sramIndex = inMsg.addr[4 +: ringPkg::sramIdxW];
	assign sramWrite = isStx && isSram;
	assign sramWriteData = inMsg.data;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			stageMsg.seq <= '0;
			stageMsg.opm <= ringPkg::ringOpm'({8'h00, ringPkg::opIdle});
			stageMsg.addr <= '0;
			stageMsg.data <= '0;
			answer <= 1'b0;
			error <= 1'b0;
			dataSrc <= ringPkg::srcZero;
		end
		else
		begin
			stageMsg.seq <= inMsg.seq;
			stageMsg.opm <= inMsg.opm;
			stageMsg.addr <= inMsg.addr;
			stageMsg.data <= inMsg.data;
			answer <= isCcmd || (isMemOp && (inWin || isBad));
			error <= isMemOp && isBad;
			dataSrc <= srcNext;
		end
	end

	// SRAM write only for a store, and never to an unknown tile
	assert property (@(posedge clock) disable iff (!rstN)
		sramWrite |-> (op == ringPkg::opStx) && !$isunknown(sramIndex));

endmodule

// File: tileRom.sv
/* boot tile ROM, 128 bits wide, synchronous read,
   contents from bootRom.hex */
`timescale 1ns/1ps

module tileRom (
	input logic clock,
	input logic [ringPkg::romIdxW-1:0] index,
	output logic [ringPkg::tileW-1:0] tile
);

	logic [ringPkg::tileW-1:0] romMem [ringPkg::romTiles];

	// tiles not listed in the hex file read as zero
	initial
	begin
		for (int i = 0; i < ringPkg::romTiles; i++)
			romMem[i] = '0;
		$readmemh("bootRom.hex", romMem);
	end

	always_ff @(posedge clock)
	begin
		tile <= romMem[index];  // registered read
	end

endmodule

// File: tileSram.sv
/* tile SRAM, 128 bits wide, synchronous read with
   old data returned on a same-cycle write */
`timescale 1ns/1ps

module tileSram (
	input logic clock,
	input logic [ringPkg::sramIdxW-1:0] readIndex,
	input logic writeEnable,
	input logic [ringPkg::sramIdxW-1:0] writeIndex,
	input logic [ringPkg::tileW-1:0] writeData,
	output logic [ringPkg::tileW-1:0] tile
);

	logic [ringPkg::tileW-1:0] sramMem [ringPkg::sramTiles];

	always_ff @(posedge clock)
	begin
		if (writeEnable)
			sramMem[writeIndex] <= writeData;
		tile <= sramMem[readIndex];  // sees the tile before this write
	end

	// once the write strobe has settled out of reset it never goes X again
	assert property (@(posedge clock)
		!$isunknown($past(writeEnable)) |-> !$isunknown(writeEnable));

endmodule

// File: ringRespBuild.sv
/* response stage: builds the answer opm and data,
   registers answer or pass-through message */
`timescale 1ns/1ps

module ringRespBuild (
	input logic clock,
	input logic rstN,
	ringMsgIf.dst stageMsg,
	input logic answer,
	input logic error,
	input logic [ringPkg::srcW-1:0] dataSrc,
	input logic [ringPkg::tileW-1:0] romTile,
	input logic [ringPkg::tileW-1:0] sramTile,
	output logic [ringPkg::seqW-1:0] seqOut,
	output ringPkg::ringOpm opmOut,
	output logic [ringPkg::addrW-1:0] addrOut,
	output logic [ringPkg::tileW-1:0] dataOut
);

	ringPkg::ringOpm respOpm;
	logic [ringPkg::tileW-1:0] respData;
	logic isStore;
	logic isCcmd;

	assign isStore = (stageMsg.opm.req.op == ringPkg::opStx);
	assign isCcmd = (stageMsg.opm.req.op[7:4] == ringPkg::ccmdNibble);

	always_comb
	begin
		respOpm.resp.flags = stageMsg.opm.req.flags;
		respOpm.resp.tag = stageMsg.opm.req.tag;
		respOpm.resp.kind = isStore ? ringPkg::kindOkSt : ringPkg::kindOkLd;
		respOpm.resp.status = error ? ringPkg::statusError : stageMsg.opm.req.tag;
		case (dataSrc)
			ringPkg::srcRom: respData = romTile;
			ringPkg::srcSram: respData = sramTile;
			ringPkg::srcNop: respData = ringPkg::nopFill;
			ringPkg::srcRts: respData = ringPkg::rtsFill;
			default: respData = '0;  // zero page, ccmd, error
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			seqOut <= '0;
			opmOut <= ringPkg::ringOpm'({8'h00, ringPkg::opIdle});
			addrOut <= '0;
			dataOut <= '0;
		end
		else
		begin
			seqOut <= stageMsg.seq;
			opmOut <= answer ? respOpm : stageMsg.opm;
			addrOut <= stageMsg.addr;
			dataOut <= answer ? respData : stageMsg.data;
		end
	end

	// control commands are plain load acks with no data
	assert property (@(posedge clock) disable iff (!rstN)
		isCcmd |-> (answer && !error) ##1
			((opmOut.resp.kind == ringPkg::kindOkLd) && (dataOut == '0)));

endmodule

// File: ringRomNode.sv
/* boot tile memory node on the ring bus: two-cycle pass-through
   or answer for ROM, SRAM and fill pages */
`timescale 1ns/1ps

module ringRomNode (
	input logic clock,
	input logic rstN,
	input logic [ringPkg::seqW-1:0] seqIn,
	input logic [ringPkg::opmW-1:0] opmIn,
	input logic [ringPkg::addrW-1:0] addrIn,
	input logic [ringPkg::tileW-1:0] dataIn,
	output logic [ringPkg::seqW-1:0] seqOut,
	output logic [ringPkg::opmW-1:0] opmOut,
	output logic [ringPkg::addrW-1:0] addrOut,
	output logic [ringPkg::tileW-1:0] dataOut
);

	ringMsgIf inMsg ();
	ringMsgIf stageMsg ();

	logic [ringPkg::romIdxW-1:0] romIndex;
	logic [ringPkg::sramIdxW-1:0] sramIndex;
	logic sramWrite;
	logic [ringPkg::tileW-1:0] sramWriteData;
	logic [ringPkg::tileW-1:0] romTile;
	logic [ringPkg::tileW-1:0] sramTile;
	logic answer;
	logic error;
	logic [ringPkg::srcW-1:0] dataSrc;

	assign inMsg.seq = seqIn;
	assign inMsg.opm = opmIn;
	assign inMsg.addr = addrIn;
	assign inMsg.data = dataIn;

	ringNodeCtrl u_ctrl (.clock(clock), .rstN(rstN), .inMsg(inMsg), .stageMsg(stageMsg),
		.romIndex(romIndex), .sramIndex(sramIndex), .sramWrite(sramWrite),
		.sramWriteData(sramWriteData), .answer(answer), .error(error), .dataSrc(dataSrc));

	tileRom u_rom (.clock(clock), .index(romIndex), .tile(romTile));

	// single port, read and write share the index
	tileSram u_sram (.clock(clock), .readIndex(sramIndex), .writeEnable(sramWrite),
		.writeIndex(sramIndex), .writeData(sramWriteData), .tile(sramTile));

	ringRespBuild u_resp (.clock(clock), .rstN(rstN), .stageMsg(stageMsg), .answer(answer),
		.error(error), .dataSrc(dataSrc), .romTile(romTile), .sramTile(sramTile),
		.seqOut(seqOut), .opmOut(opmOut), .addrOut(addrOut), .dataOut(dataOut));

endmodule

// File: tbRingRomNode.sv
/* directed testbench for the ring memory node: message tasks, compare tasks,
   ROM and SRAM models, timeout and summary */
`timescale 1ns/1ps

module tbRingRomNode;

	localparam int testCycles = 73;  // reset 10, tests 18+14+4+5+6+16
	localparam int cycleLimit = testCycles + 40;

	logic clock;
	logic rstN;
	logic [ringPkg::seqW-1:0] seqIn;
	logic [ringPkg::seqW-1:0] seqOut;
	logic [ringPkg::opmW-1:0] opmIn;
	logic [ringPkg::opmW-1:0] opmOut;
	logic [ringPkg::addrW-1:0] addrIn;
	logic [ringPkg::addrW-1:0] addrOut;
	logic [ringPkg::tileW-1:0] dataIn;
	logic [ringPkg::tileW-1:0] dataOut;

	logic [ringPkg::tileW-1:0] romImage [16];  // tiles listed in the hex file
	logic [ringPkg::tileW-1:0] sramModel [ringPkg::sramTiles];
	bit sramKnown [ringPkg::sramTiles];

	// expected responses in message order
	logic [ringPkg::seqW-1:0] expSeqQ [$];
	ringPkg::ringOpm expOpmQ [$];
	logic [ringPkg::addrW-1:0] expAddrQ [$];
	logic [ringPkg::tileW-1:0] expDataQ [$];
	bit knownQ [$];
	int dueQ [$];

	int seed = 32'hc1d2;
	int clockCount = 0;
	int errorCount = 0;
	int testStartErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	string testName;

	ringRomNode u_dut (.clock(clock), .rstN(rstN), .seqIn(seqIn), .opmIn(opmIn),
		.addrIn(addrIn), .dataIn(dataIn), .seqOut(seqOut), .opmOut(opmOut),
		.addrOut(addrOut), .dataOut(dataOut));

	always #4 clock = ~clock;  // 8 ns period

	always @(posedge clock)
	begin
		clockCount = clockCount + 1;
		if (clockCount >= cycleLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic logic [ringPkg::seqW-1:0] randSeq();
		logic [31:0] word;
		word = $random(seed);
		return word[15:0];
	endfunction

	function automatic logic [ringPkg::tileW-1:0] randTile();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	function automatic ringPkg::ringOpm reqOpm(logic [3:0] flags, logic [3:0] tag,
		logic [7:0] op);
		return ringPkg::ringOpm'({flags, tag, op});
	endfunction

	// expected answer word built from the request word
	function automatic ringPkg::ringOpm ackOpm(ringPkg::ringOpm req, bit store, bit bad);
		ringPkg::ringOpm ack;
		ack.resp.flags = req.req.flags;
		ack.resp.tag = req.req.tag;
		ack.resp.kind = store ? ringPkg::kindOkSt : ringPkg::kindOkLd;
		ack.resp.status = bad ? ringPkg::statusError : req.req.tag;
		return ack;
	endfunction

	task automatic checkOpm(ringPkg::ringOpm expected, ringPkg::ringOpm actual);
		if (actual !== expected)
		begin
			$display("FAILED %s opm: expected %h, actual %h", testName, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkWord(string field, logic [ringPkg::addrW-1:0] expected,
		logic [ringPkg::addrW-1:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s %s: expected %h, actual %h", testName, field, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkTile(logic [ringPkg::tileW-1:0] expected,
		logic [ringPkg::tileW-1:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s data: expected %h, actual %h", testName, expected, actual);
			errorCount++;
		end
	endtask

	// one clock, then check every response due now
	task automatic stepCycle();
		logic [ringPkg::tileW-1:0] expData;
		bit known;
		@(posedge clock);
		#1;
		while (dueQ.size() > 0 && dueQ[0] == clockCount)
		begin
			expData = expDataQ.pop_front();
			known = knownQ.pop_front();
			checkWord("seq", 32'(expSeqQ.pop_front()), 32'(seqOut));
			checkOpm(expOpmQ.pop_front(), opmOut);
			checkWord("addr", expAddrQ.pop_front(), addrOut);
			if (known)
				checkTile(expData, dataOut);
			dueQ.delete(0);
		end
	endtask

	task automatic sendMessage(logic [ringPkg::seqW-1:0] seq, ringPkg::ringOpm opm,
		logic [ringPkg::addrW-1:0] addr, logic [ringPkg::tileW-1:0] data,
		ringPkg::ringOpm expOpm, logic [ringPkg::tileW-1:0] expData, bit known);
		seqIn = seq;
		opmIn = opm;
		addrIn = addr;
		dataIn = data;
		expSeqQ.push_back(seq);
		expOpmQ.push_back(expOpm);
		expAddrQ.push_back(addr);
		expDataQ.push_back(expData);
		knownQ.push_back(known);
		dueQ.push_back(clockCount + 2);  // answer leaves after the second edge
		stepCycle();
	endtask

	task automatic request(ringPkg::ringOpm opm, logic [ringPkg::addrW-1:0] addr,
		logic [ringPkg::tileW-1:0] data, bit bad, logic [ringPkg::tileW-1:0] expData,
		bit known);
		sendMessage(randSeq(), opm, addr, data,
			ackOpm(opm, opm.req.op == ringPkg::opStx, bad), expData, known);
	endtask

	task automatic passThrough(ringPkg::ringOpm opm, logic [ringPkg::addrW-1:0] addr);
		logic [ringPkg::tileW-1:0] data;
		data = randTile();
		sendMessage(randSeq(), opm, addr, data, opm, data, 1'b1);
	endtask

	task automatic endTest();
		seqIn = '0;
		opmIn = '0;
		addrIn = '0;
		dataIn = '0;
		while (dueQ.size() > 0)
			stepCycle();
		testsRun++;
		if (errorCount == testStartErrors)
			$display("%s: ok", testName);
		else
		begin
			$display("%s: %0d errors", testName, errorCount - testStartErrors);
			testsFailed++;
		end
		testStartErrors = errorCount;
	endtask

	task automatic romLoads();
		testName = "romLoads";
		for (int i = 0; i < 16; i++)
			request(reqOpm(4'h1, i[3:0], ringPkg::opLdx), {17'h0, i[10:0], 4'h0},
				randTile(), 1'b0, romImage[i], 1'b1);
		request(reqOpm(4'h2, 4'h9, ringPkg::opPfx), 32'h0000_0058, randTile(), 1'b0,
			romImage[5], 1'b1);
		endTest();
	endtask

	task automatic sramStoreLoad();
		logic [8:0] idx;
		logic [ringPkg::addrW-1:0] addr;
		logic [ringPkg::tileW-1:0] tile;
		testName = "sramStoreLoad";
		for (int k = 0; k < 4; k++)
		begin
			idx = {k[1:0], 7'h2a};
			addr = {14'h0, 5'b00110, idx, 4'h3};
			repeat (2)  // the second store returns the first tile
			begin
				tile = randTile();
				request(reqOpm(4'h0, tile[3:0], ringPkg::opStx), addr, tile, 1'b0,
					sramModel[idx], sramKnown[idx]);
				sramModel[idx] = tile;
				sramKnown[idx] = 1'b1;
			end
			request(reqOpm(4'h4, 4'h6, ringPkg::opLdx), addr, randTile(), 1'b0,
				sramModel[idx], 1'b1);
		end
		request(reqOpm(4'h0, 4'hb, ringPkg::opSpx), 32'h0000_caa0, randTile(), 1'b0,
			sramModel[9'h0aa], 1'b1);
		endTest();
	endtask

	task automatic specialPages();
		testName = "specialPages";
		request(reqOpm(4'h3, 4'h1, ringPkg::opLdx), 32'h0001_0400, randTile(), 1'b0,
			'0, 1'b1);
		request(reqOpm(4'h3, 4'h2, ringPkg::opLdx), 32'h0002_0120, randTile(), 1'b0,
			{8{16'h3000}}, 1'b1);  // nop pattern
		request(reqOpm(4'h3, 4'h3, ringPkg::opLdx), 32'h0003_fff0, randTile(), 1'b0,
			{8{16'h3010}}, 1'b1);  // return pattern
		endTest();
	endtask

	task automatic badAddresses();
		testName = "badAddresses";
		request(reqOpm(4'h5, 4'h1, ringPkg::opLdx), 32'hc000_0040, randTile(), 1'b1, '0, 1'b1);
		request(reqOpm(4'h5, 4'h2, ringPkg::opStx), 32'h4000_1230, randTile(), 1'b1, '0, 1'b1);
		request(reqOpm(4'h5, 4'h3, ringPkg::opLdx), 32'h00f0_0000, randTile(), 1'b1, '0, 1'b1);
		request(reqOpm(4'h5, 4'h4, ringPkg::opStx), 32'h00f0_0000, randTile(), 1'b1, '0, 1'b1);
		endTest();
	endtask

	task automatic controlAndPassThrough();
		testName = "controlAndPassThrough";
		request(reqOpm(4'h6, 4'h3, 8'h81), {randSeq(), randSeq()}, randTile(), 1'b0, '0, 1'b1);
		request(reqOpm(4'hf, 4'hc, 8'h8f), {randSeq(), randSeq()}, randTile(), 1'b0, '0, 1'b1);
		passThrough(reqOpm(4'h0, 4'h0, ringPkg::opIdle), {randSeq(), randSeq()});
		passThrough(reqOpm(4'h1, 4'h2, ringPkg::opLdx), 32'h1000_0000);  // beyond the node
		passThrough(reqOpm(4'h2, 4'h7, {ringPkg::kindOkLd, 4'h7}), 32'h0000_0100);
		endTest();
	endtask

	task automatic resetAndStream();
		testName = "resetAndStream";
		rstN = 1'b0;
		seqIn = randSeq();
		opmIn = reqOpm(4'h1, 4'h1, ringPkg::opLdx);
		addrIn = 32'h0000_0010;
		repeat (3)
			stepCycle();
		// second pass shows the cleared stage register
		repeat (2)
		begin
			checkOpm(reqOpm(4'h0, 4'h0, ringPkg::opIdle), opmOut);
			checkWord("seq", '0, 32'(seqOut));
			checkWord("addr", '0, addrOut);
			checkTile('0, dataOut);
			rstN = 1'b1;
			seqIn = '0;
			opmIn = '0;
			addrIn = '0;
			stepCycle();
		end
		for (int k = 0; k < 10; k++)
			case (k % 5)
				0: request(reqOpm(4'h7, k[3:0], ringPkg::opLdx), {17'h0, k[10:0], 4'h0},
					randTile(), 1'b0, romImage[k], 1'b1);
				1: request(reqOpm(4'h7, k[3:0], ringPkg::opLdx), 32'h0000_caa0,
					randTile(), 1'b0, sramModel[9'h0aa], 1'b1);
				2: request(reqOpm(4'h7, k[3:0], 8'h82), {randSeq(), randSeq()},
					randTile(), 1'b0, '0, 1'b1);
				3: passThrough(reqOpm(4'h7, k[3:0], ringPkg::opIdle), {randSeq(), randSeq()});
				default: request(reqOpm(4'h7, k[3:0], ringPkg::opStx), 32'h8000_1230,
					randTile(), 1'b1, '0, 1'b1);
			endcase
		endTest();
	endtask

	initial
	begin
		clock = 1'b0;
		rstN = 1'b0;
		seqIn = '0;
		opmIn = '0;
		addrIn = '0;
		dataIn = '0;
		$readmemh("bootRom.hex", romImage);
		repeat (10)
			@(posedge clock);
		#1;
		rstN = 1'b1;
		romLoads();
		sramStoreLoad();
		specialPages();
		badAddresses();
		controlAndPassThrough();
		resetAndStream();
		$display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: bootRom.hex
// one 128-bit boot tile per line, 32 hex digits, tile 0 first
c0de00005a5a00000000ffff13579bd0
c0de00015a5a11110000fffe13579bd1
c0de00025a5a22220000fffd13579bd2
c0de00035a5a33330000fffc13579bd3
c0de00045a5a44440000fffb13579bd4
c0de00055a5a55550000fffa13579bd5
c0de00065a5a66660000fff913579bd6
c0de00075a5a77770000fff813579bd7
c0de00085a5a88880000fff713579bd8
c0de00095a5a99990000fff613579bd9
c0de000a5a5aaaaa0000fff513579bda
c0de000b5a5abbbb0000fff413579bdb
c0de000c5a5acccc0000fff313579bdc
c0de000d5a5adddd0000fff213579bdd
c0de000e5a5aeeee0000fff113579bde
c0de000f5a5affff0000fff013579bdf

// File: all.f
ringPkg.sv
ringMsgIf.sv
ringNodeCtrl.sv
tileRom.sv
tileSram.sv
ringRespBuild.sv
ringRomNode.sv
tbRingRomNode.sv

// File: Makefile
# Verilator build and run of the ring memory node testbench
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbRingRomNode
FILELIST = all.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP), look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
